/* src/rs_pkg.sv */
package rs_pkg;

	////////////////////
	// Machine sizes
	////////////////////

	localparam int PRF_SIZE = 64; // Physical registers
	localparam int ROB_SIZE = 32; // ROB entries

	////////////////////
	// Payload types
	////////////////////

	typedef logic [63:0] word_t; // Operand or result value
	typedef logic [$clog2(PRF_SIZE)-1:0] prf_tag_t; // Physical register tag
	typedef logic [$clog2(ROB_SIZE):0] rob_idx_t; // ROB index plus wrap bit
	typedef logic [5:0] op_type_t; // Instruction class code

	// ALU operation, default must stay zero so gated entry outputs OR cleanly
	typedef enum logic [4:0] {
		ALU_DEFAULT, // No operation
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL, // Shift left logical
		ALU_SRL, // Shift right logical
		ALU_SRA, // Shift right arithmetic
		ALU_SLT, // Set less than, signed
		ALU_SLTU, // Set less than, unsigned
		ALU_CMPEQ // Compare equal
	} alu_func_e;

	// Target functional unit, default zero as above
	typedef enum logic [2:0] {
		FU_DEFAULT, // Nothing selected
		FU_ALU,
		FU_MULT,
		FU_BRANCH,
		FU_MEM
	} fu_select_e;

endpackage

/* src/cdb_if.sv */
interface cdb_if;
	import rs_pkg::*;

	logic cdb1_valid; // Broadcast 1 present this cycle
	prf_tag_t cdb1_tag; // Tag being produced
	word_t cdb1_value; // Its result
	logic cdb2_valid; // Broadcast 2 present this cycle
	prf_tag_t cdb2_tag;
	word_t cdb2_value;

	// Driven from the top-level CDB ports
	modport source (
		output cdb1_valid, cdb1_tag, cdb1_value,
		output cdb2_valid, cdb2_tag, cdb2_value
	);

	// Snooped by every entry
	modport listen (
		input cdb1_valid, cdb1_tag, cdb1_value,
		input cdb2_valid, cdb2_tag, cdb2_value
	);

endinterface

/* src/rs_entry_if.sv */
interface rs_entry_if;
	import rs_pkg::*;

	////////////////////
	// Dispatch side
	////////////////////

	logic load1, load2; // Capture strobes, at most one high
	word_t inst1_opa, inst1_opb; // Value, or tag in the low bits
	logic inst1_opa_valid, inst1_opb_valid; // Low means waiting on a tag
	alu_func_e inst1_alu_func;
	fu_select_e inst1_fu_select;
	op_type_t inst1_op_type;
	prf_tag_t inst1_dest_tag;
	rob_idx_t inst1_rob_idx;
	word_t inst2_opa, inst2_opb; // Same fields for slot 2
	logic inst2_opa_valid, inst2_opb_valid;
	alu_func_e inst2_alu_func;
	fu_select_e inst2_fu_select;
	op_type_t inst2_op_type;
	prf_tag_t inst2_dest_tag;
	rob_idx_t inst2_rob_idx;

	////////////////////
	// Entry and issue side
	////////////////////

	logic ready; // In use with both operands present
	logic available; // Free now or freed by this cycle's grant
	logic free_enable; // Grant from the selector
	word_t opa_out, opb_out; // Zero unless granted
	prf_tag_t dest_tag_out;
	alu_func_e alu_func_out;
	fu_select_e fu_select_out;
	op_type_t op_type_out;
	rob_idx_t rob_idx_out;

	modport dispatch (
		output load1, load2,
		output inst1_opa, inst1_opb, inst1_opa_valid, inst1_opb_valid, inst1_alu_func,
		output inst1_fu_select, inst1_op_type, inst1_dest_tag, inst1_rob_idx,
		output inst2_opa, inst2_opb, inst2_opa_valid, inst2_opb_valid, inst2_alu_func,
		output inst2_fu_select, inst2_op_type, inst2_dest_tag, inst2_rob_idx,
		input available
	);

	modport entry (
		input load1, load2,
		input inst1_opa, inst1_opb, inst1_opa_valid, inst1_opb_valid, inst1_alu_func,
		input inst1_fu_select, inst1_op_type, inst1_dest_tag, inst1_rob_idx,
		input inst2_opa, inst2_opb, inst2_opa_valid, inst2_opb_valid, inst2_alu_func,
		input inst2_fu_select, inst2_op_type, inst2_dest_tag, inst2_rob_idx,
		input free_enable,
		output ready, available, opa_out, opb_out, dest_tag_out,
		output alu_func_out, fu_select_out, op_type_out, rob_idx_out
	);

	modport issue (
		input ready, opa_out, opb_out, dest_tag_out,
		input alu_func_out, fu_select_out, op_type_out, rob_idx_out,
		output free_enable
	);

endinterface

/* src/rs_entry.sv */
module rs_entry (
	input logic clock,
	input logic reset,
	input logic rs_free, // Mispredict flush
	cdb_if.listen cdb,
	rs_entry_if.entry slot
);
	import rs_pkg::*;

	// Control state
	logic in_use_q, in_use_next;
	logic opa_valid_q, opa_valid_next; // Operand holds a value, not a tag
	logic opb_valid_q, opb_valid_next;

	// Payload
	word_t opa_q, opa_next;
	word_t opb_q, opb_next;
	prf_tag_t dest_tag_q, dest_tag_next;
	rob_idx_t rob_idx_q, rob_idx_next;
	alu_func_e alu_func_q, alu_func_next;
	fu_select_e fu_select_q, fu_select_next;
	op_type_t op_type_q, op_type_next;

	logic wake_a1, wake_b1, wake_a2, wake_b2; // Tag hits per operand and bus

	////////////////////
	// CDB snoop
	////////////////////

	// Waiting operands keep their tag in the low bits
	assign wake_a1 = cdb.cdb1_valid && in_use_q && !opa_valid_q
		&& (cdb.cdb1_tag == opa_q[$bits(prf_tag_t)-1:0]);
	assign wake_b1 = cdb.cdb1_valid && in_use_q && !opb_valid_q
		&& (cdb.cdb1_tag == opb_q[$bits(prf_tag_t)-1:0]);
	assign wake_a2 = cdb.cdb2_valid && in_use_q && !opa_valid_q
		&& (cdb.cdb2_tag == opa_q[$bits(prf_tag_t)-1:0]);
	assign wake_b2 = cdb.cdb2_valid && in_use_q && !opb_valid_q
		&& (cdb.cdb2_tag == opb_q[$bits(prf_tag_t)-1:0]);

	////////////////////
	// Next state
	////////////////////

	always_comb
	begin
		opa_next = opa_q; // Hold by default
		opb_next = opb_q;
		opa_valid_next = opa_valid_q;
		opb_valid_next = opb_valid_q;
		dest_tag_next = dest_tag_q;
		rob_idx_next = rob_idx_q;
		alu_func_next = alu_func_q;
		fu_select_next = fu_select_q;
		op_type_next = op_type_q;
		in_use_next = in_use_q && !slot.free_enable; // Grant frees the entry
		if (rs_free)
		begin
			in_use_next = 1'b0; // Flush beats any load
			opa_valid_next = 1'b0;
			opb_valid_next = 1'b0;
		end
		else if (slot.load1)
		begin
			opa_next = slot.inst1_opa;
			opb_next = slot.inst1_opb;
			opa_valid_next = slot.inst1_opa_valid;
			opb_valid_next = slot.inst1_opb_valid;
			dest_tag_next = slot.inst1_dest_tag;
			rob_idx_next = slot.inst1_rob_idx;
			alu_func_next = slot.inst1_alu_func;
			fu_select_next = slot.inst1_fu_select;
			op_type_next = slot.inst1_op_type;
			in_use_next = 1'b1;
		end
		else if (slot.load2)
		begin
			opa_next = slot.inst2_opa;
			opb_next = slot.inst2_opb;
			opa_valid_next = slot.inst2_opa_valid;
			opb_valid_next = slot.inst2_opb_valid;
			dest_tag_next = slot.inst2_dest_tag;
			rob_idx_next = slot.inst2_rob_idx;
			alu_func_next = slot.inst2_alu_func;
			fu_select_next = slot.inst2_fu_select;
			op_type_next = slot.inst2_op_type;
			in_use_next = 1'b1;
		end
		else
		begin
			// Wakeup, CDB2 checked last
			if (wake_a1)
			begin
				opa_next = cdb.cdb1_value;
				opa_valid_next = 1'b1;
			end
			if (wake_b1)
			begin
				opb_next = cdb.cdb1_value;
				opb_valid_next = 1'b1;
			end
			if (wake_a2)
			begin
				opa_next = cdb.cdb2_value;
				opa_valid_next = 1'b1;
			end
			if (wake_b2)
			begin
				opb_next = cdb.cdb2_value;
				opb_valid_next = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use_q <= 1'b0;
			opa_valid_q <= 1'b0;
			opb_valid_q <= 1'b0;
		end
		else
		begin
			in_use_q <= in_use_next;
			opa_valid_q <= opa_valid_next;
			opb_valid_q <= opb_valid_next;
		end
	end

	always_ff @(posedge clock)
	begin
		opa_q <= opa_next;
		opb_q <= opb_next;
		dest_tag_q <= dest_tag_next;
		rob_idx_q <= rob_idx_next;
		alu_func_q <= alu_func_next;
		fu_select_q <= fu_select_next;
		op_type_q <= op_type_next;
	end

	////////////////////
	// Outputs
	////////////////////

	assign slot.ready = in_use_q && opa_valid_q && opb_valid_q;
	assign slot.available = slot.ready ? slot.free_enable : !in_use_q; // Refill on issue
	assign slot.opa_out = slot.free_enable ? opa_q : '0; // Gated for OR merge
	assign slot.opb_out = slot.free_enable ? opb_q : '0;
	assign slot.dest_tag_out = slot.free_enable ? dest_tag_q : '0;
	assign slot.rob_idx_out = slot.free_enable ? rob_idx_q : '0;
	assign slot.alu_func_out = slot.free_enable ? alu_func_q : ALU_DEFAULT;
	assign slot.fu_select_out = slot.free_enable ? fu_select_q : FU_DEFAULT;
	assign slot.op_type_out = slot.free_enable ? op_type_q : '0;

	// Dispatch never steers both slots here
	a_single_load: assert property (@(posedge clock) disable iff (reset)
		!(slot.load1 && slot.load2));

	// Selector grants only ready entries
	a_grant_ready: assert property (@(posedge clock) disable iff (reset)
		slot.free_enable |-> slot.ready);

endmodule

/* src/rs_dispatch.sv */
module rs_dispatch #(
	parameter int RS_SIZE = 8
) (
	input logic clock,
	input logic reset,
	input logic inst1_valid,
	input logic inst2_valid,
	input rs_pkg::word_t inst1_opa,
	input rs_pkg::word_t inst1_opb,
	input logic inst1_opa_valid,
	input logic inst1_opb_valid,
	input rs_pkg::alu_func_e inst1_alu_func,
	input rs_pkg::fu_select_e inst1_fu_select,
	input rs_pkg::op_type_t inst1_op_type,
	input rs_pkg::prf_tag_t inst1_dest_tag,
	input rs_pkg::rob_idx_t inst1_rob_idx,
	input rs_pkg::word_t inst2_opa,
	input rs_pkg::word_t inst2_opb,
	input logic inst2_opa_valid,
	input logic inst2_opb_valid,
	input rs_pkg::alu_func_e inst2_alu_func,
	input rs_pkg::fu_select_e inst2_fu_select,
	input rs_pkg::op_type_t inst2_op_type,
	input rs_pkg::prf_tag_t inst2_dest_tag,
	input rs_pkg::rob_idx_t inst2_rob_idx,
	rs_entry_if.dispatch slots [RS_SIZE],
	output logic dispatch_stall
);

	localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1; // Entry index
	localparam int CNT_W = $clog2(RS_SIZE + 3); // Counts up to RS_SIZE plus two

	logic [RS_SIZE-1:0] avail; // Per-entry available bits
	logic [RS_SIZE-1:0] loaded; // Entries strobed this cycle
	logic first_found, second_found;
	logic [IDX_W-1:0] first_idx, second_idx; // Lowest and next free entry
	logic [CNT_W-1:0] free_count; // Free entries this cycle
	logic [CNT_W-1:0] req_count; // Valid instructions offered
	logic [CNT_W-1:0] load_count; // Load strobes actually raised
	logic [CNT_W-1:0] occupancy_q; // Entries held after the last edge

	////////////////////
	// Free entry scan
	////////////////////

	always_comb
	begin
		first_found = 1'b0;
		second_found = 1'b0;
		first_idx = '0;
		second_idx = '0;
		free_count = '0;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (avail[i])
			begin
				free_count = free_count + CNT_W'(1);
				if (!first_found)
				begin
					first_found = 1'b1;
					first_idx = IDX_W'(i);
				end
				else if (!second_found)
				begin
					second_found = 1'b1;
					second_idx = IDX_W'(i);
				end
			end
		end
	end

	assign req_count = CNT_W'(inst1_valid) + CNT_W'(inst2_valid);
	assign dispatch_stall = (free_count < req_count); // All or nothing

	////////////////////
	// Per-entry steering
	////////////////////

	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_slot
		assign avail[i] = slots[i].available;
		// inst1 takes the lowest, inst2 the next or the lowest when alone
		assign slots[i].load1 = !dispatch_stall && inst1_valid && first_found
			&& (first_idx == IDX_W'(i));
		assign slots[i].load2 = !dispatch_stall && inst2_valid
			&& (inst1_valid ? (second_found && second_idx == IDX_W'(i))
			: (first_found && first_idx == IDX_W'(i)));
		assign loaded[i] = slots[i].load1 || slots[i].load2;
		assign slots[i].inst1_opa = inst1_opa; // Fields are broadcast
		assign slots[i].inst1_opb = inst1_opb;
		assign slots[i].inst1_opa_valid = inst1_opa_valid;
		assign slots[i].inst1_opb_valid = inst1_opb_valid;
		assign slots[i].inst1_alu_func = inst1_alu_func;
		assign slots[i].inst1_fu_select = inst1_fu_select;
		assign slots[i].inst1_op_type = inst1_op_type;
		assign slots[i].inst1_dest_tag = inst1_dest_tag;
		assign slots[i].inst1_rob_idx = inst1_rob_idx;
		assign slots[i].inst2_opa = inst2_opa;
		assign slots[i].inst2_opb = inst2_opb;
		assign slots[i].inst2_opa_valid = inst2_opa_valid;
		assign slots[i].inst2_opb_valid = inst2_opb_valid;
		assign slots[i].inst2_alu_func = inst2_alu_func;
		assign slots[i].inst2_fu_select = inst2_fu_select;
		assign slots[i].inst2_op_type = inst2_op_type;
		assign slots[i].inst2_dest_tag = inst2_dest_tag;
		assign slots[i].inst2_rob_idx = inst2_rob_idx;
	end

	// Count of strobes the entries really see
	always_comb
	begin
		load_count = '0;
		for (int i = 0; i < RS_SIZE; i++)
			load_count = load_count + CNT_W'(loaded[i]);
	end

	// Held entries plus this cycle's dispatches, a flush only lowers it
	always_ff @(posedge clock)
	begin
		if (reset)
			occupancy_q <= '0;
		else
			occupancy_q <= CNT_W'(RS_SIZE) - free_count + load_count;
	end

	a_no_overfill: assert property (@(posedge clock) disable iff (reset)
		occupancy_q <= CNT_W'(RS_SIZE));

endmodule

/* src/rs_issue_select.sv */
module rs_issue_select #(
	parameter int RS_SIZE = 8
) (
	input logic fu_ready, // Unit accepts this cycle
	rs_entry_if.issue slots [RS_SIZE],
	output logic issue_valid,
	output rs_pkg::word_t issue_opa,
	output rs_pkg::word_t issue_opb,
	output rs_pkg::prf_tag_t issue_dest_tag,
	output rs_pkg::alu_func_e issue_alu_func,
	output rs_pkg::fu_select_e issue_fu_select,
	output rs_pkg::op_type_t issue_op_type,
	output rs_pkg::rob_idx_t issue_rob_idx
);
	import rs_pkg::*;

	logic [RS_SIZE-1:0] ready_v; // Ready bits by entry
	logic [RS_SIZE-1:0] grant; // One-hot or zero
	word_t opa_v [RS_SIZE];
	word_t opb_v [RS_SIZE];
	prf_tag_t dest_tag_v [RS_SIZE];
	alu_func_e alu_func_v [RS_SIZE];
	fu_select_e fu_select_v [RS_SIZE];
	op_type_t op_type_v [RS_SIZE];
	rob_idx_t rob_idx_v [RS_SIZE];
	logic [$bits(alu_func_e)-1:0] alu_acc; // Raw OR before enum cast
	logic [$bits(fu_select_e)-1:0] fu_acc;

	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_slot
		assign ready_v[i] = slots[i].ready;
		assign slots[i].free_enable = grant[i];
		assign opa_v[i] = slots[i].opa_out; // Already gated by the entry
		assign opb_v[i] = slots[i].opb_out;
		assign dest_tag_v[i] = slots[i].dest_tag_out;
		assign alu_func_v[i] = slots[i].alu_func_out;
		assign fu_select_v[i] = slots[i].fu_select_out;
		assign op_type_v[i] = slots[i].op_type_out;
		assign rob_idx_v[i] = slots[i].rob_idx_out;
	end

	////////////////////
	// Lowest-index grant
	////////////////////

	always_comb
	begin : p_grant
		logic taken; // A lower entry already claimed
		taken = 1'b0;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			grant[i] = fu_ready && ready_v[i] && !taken;
			taken = taken || ready_v[i];
		end
	end

	assign issue_valid = |grant;

	////////////////////
	// Field merge
	////////////////////

	always_comb
	begin
		issue_opa = '0;
		issue_opb = '0;
		issue_dest_tag = '0;
		issue_op_type = '0;
		issue_rob_idx = '0;
		alu_acc = '0;
		fu_acc = '0;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			issue_opa = issue_opa | opa_v[i];
			issue_opb = issue_opb | opb_v[i];
			issue_dest_tag = issue_dest_tag | dest_tag_v[i];
			issue_op_type = issue_op_type | op_type_v[i];
			issue_rob_idx = issue_rob_idx | rob_idx_v[i];
			alu_acc = alu_acc | alu_func_v[i];
			fu_acc = fu_acc | fu_select_v[i];
		end
	end

	assign issue_alu_func = alu_func_e'(alu_acc); // Defaults are zero
	assign issue_fu_select = fu_select_e'(fu_acc);

	a_grant_onehot: assert final ($onehot0(grant));

	// Ungranted entries must present zeros for the merge to hold
	a_idle_zero: assert final (issue_valid || (issue_opa == '0 && issue_opb == '0));

endmodule

/* src/rs_station.sv */
module rs_station #(
	parameter int RS_SIZE = 8
) (
	input logic clock,
	input logic reset,
	input logic rs_free, // Branch mispredict flush
	input logic fu_ready, // Back-pressure from the unit
	input logic inst1_valid,
	input rs_pkg::word_t inst1_opa,
	input rs_pkg::word_t inst1_opb,
	input logic inst1_opa_valid,
	input logic inst1_opb_valid,
	input rs_pkg::alu_func_e inst1_alu_func,
	input rs_pkg::fu_select_e inst1_fu_select,
	input rs_pkg::op_type_t inst1_op_type,
	input rs_pkg::prf_tag_t inst1_dest_tag,
	input rs_pkg::rob_idx_t inst1_rob_idx,
	input logic inst2_valid,
	input rs_pkg::word_t inst2_opa,
	input rs_pkg::word_t inst2_opb,
	input logic inst2_opa_valid,
	input logic inst2_opb_valid,
	input rs_pkg::alu_func_e inst2_alu_func,
	input rs_pkg::fu_select_e inst2_fu_select,
	input rs_pkg::op_type_t inst2_op_type,
	input rs_pkg::prf_tag_t inst2_dest_tag,
	input rs_pkg::rob_idx_t inst2_rob_idx,
	input logic cdb1_valid,
	input rs_pkg::prf_tag_t cdb1_tag,
	input rs_pkg::word_t cdb1_value,
	input logic cdb2_valid,
	input rs_pkg::prf_tag_t cdb2_tag,
	input rs_pkg::word_t cdb2_value,
	output logic dispatch_stall, // Not enough free entries
	output logic issue_valid,
	output rs_pkg::word_t issue_opa,
	output rs_pkg::word_t issue_opb,
	output rs_pkg::prf_tag_t issue_dest_tag,
	output rs_pkg::alu_func_e issue_alu_func,
	output rs_pkg::fu_select_e issue_fu_select,
	output rs_pkg::op_type_t issue_op_type,
	output rs_pkg::rob_idx_t issue_rob_idx
);

	cdb_if cdb_bus ();
	rs_entry_if slot_bus [RS_SIZE] ();

	assign cdb_bus.cdb1_valid = cdb1_valid; // Broadcast fan-in
	assign cdb_bus.cdb1_tag = cdb1_tag;
	assign cdb_bus.cdb1_value = cdb1_value;
	assign cdb_bus.cdb2_valid = cdb2_valid;
	assign cdb_bus.cdb2_tag = cdb2_tag;
	assign cdb_bus.cdb2_value = cdb2_value;

	rs_dispatch #(.RS_SIZE(RS_SIZE)) dispatch_inst (
		.clock, .reset, .inst1_valid, .inst2_valid,
		.inst1_opa, .inst1_opb, .inst1_opa_valid, .inst1_opb_valid, .inst1_alu_func,
		.inst1_fu_select, .inst1_op_type, .inst1_dest_tag, .inst1_rob_idx,
		.inst2_opa, .inst2_opb, .inst2_opa_valid, .inst2_opb_valid, .inst2_alu_func,
		.inst2_fu_select, .inst2_op_type, .inst2_dest_tag, .inst2_rob_idx,
		.slots(slot_bus), .dispatch_stall
	);

	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_entry
		rs_entry entry_inst (
			.clock, .reset, .rs_free,
			.cdb(cdb_bus.listen),
			.slot(slot_bus[i].entry)
		);
	end

	rs_issue_select #(.RS_SIZE(RS_SIZE)) issue_inst (
		.fu_ready, .slots(slot_bus), .issue_valid,
		.issue_opa, .issue_opb, .issue_dest_tag, .issue_alu_func,
		.issue_fu_select, .issue_op_type, .issue_rob_idx
	);

endmodule

/* test/rs_station_vectors.svh */
`ifndef RS_STATION_VECTORS_SVH
`define RS_STATION_VECTORS_SVH

////////////////////
// Row layout
////////////////////

// One renamed instruction, operand values are filled in around it
typedef struct packed {
	logic v; // Instruction present
	logic av; // Operand A is a value
	logic bv; // Operand B is a value
	prf_tag_t a_tag; // Producer tag while A waits
	prf_tag_t b_tag;
	prf_tag_t dest; // Also identifies the instruction
} inst_t;

typedef struct {
	string name;
	logic fu_ready;
	logic rs_free;
	inst_t i1;
	inst_t i2;
	logic c1_valid;
	prf_tag_t c1_tag;
	logic c2_valid;
	prf_tag_t c2_tag;
	logic exp_valid; // Expected issue_valid
	prf_tag_t exp_dest; // Issued destination, zero when idle
	logic exp_stall; // Expected dispatch_stall
} row_t;

localparam inst_t NO_INST = '0;
localparam int NUM_ROWS = 39;

// Columns: name, fu_ready, rs_free, inst1 {v, av, bv, a_tag, b_tag, dest}, inst2,
// cdb1 valid, cdb1 tag, cdb2 valid, cdb2 tag, issue_valid, issued dest, dispatch_stall
row_t rows [NUM_ROWS] = '{
	'{"reset_idle", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"disp_ready", 1, 0, '{1, 1, 1, 0, 0, 1}, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"issue_next", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 1, 0},
	'{"drained_1", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"disp_tagged", 1, 0, '{1, 0, 1, 40, 0, 2}, '{1, 0, 0, 41, 42, 3}, 0, 0, 0, 0, 0, 0, 0},
	'{"tag_wait", 1, 0, NO_INST, NO_INST, 0, 0, 1, 50, 0, 0, 0},
	'{"cdb1_wake", 1, 0, NO_INST, NO_INST, 1, 40, 0, 0, 0, 0, 0},
	'{"dual_wake", 1, 0, NO_INST, NO_INST, 1, 41, 1, 42, 1, 2, 0},
	'{"dual_issue", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 3, 0},
	'{"drained_2", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"pair_low", 1, 0, '{1, 1, 1, 0, 0, 4}, '{1, 1, 1, 0, 0, 5}, 0, 0, 0, 0, 0, 0, 0},
	'{"refill_issue", 1, 0, '{1, 1, 1, 0, 0, 6}, '{1, 0, 1, 43, 0, 7}, 0, 0, 0, 0, 1, 4, 0},
	'{"lowest_first", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 6, 0},
	'{"next_ready", 1, 0, NO_INST, NO_INST, 0, 0, 1, 43, 1, 5, 0},
	'{"cdb2_issue", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 7, 0},
	'{"drained_3", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"fill_low", 1, 0, '{1, 0, 1, 44, 0, 8}, '{1, 1, 0, 0, 45, 9}, 0, 0, 0, 0, 0, 0, 0},
	'{"fill_high", 1, 0, '{1, 1, 1, 0, 0, 10}, '{1, 1, 1, 0, 0, 11}, 0, 0, 0, 0, 0, 0, 0},
	'{"full_stall", 0, 0, '{1, 1, 1, 0, 0, 12}, '{1, 1, 1, 0, 0, 13}, 0, 0, 0, 0, 0, 0, 1},
	'{"stall_hold", 0, 0, '{1, 1, 1, 0, 0, 12}, '{1, 1, 1, 0, 0, 13}, 0, 0, 0, 0, 0, 0, 1},
	'{"one_freed", 1, 0, '{1, 1, 1, 0, 0, 12}, '{1, 1, 1, 0, 0, 13}, 0, 0, 0, 0, 1, 10, 1},
	'{"resume", 1, 0, '{1, 1, 1, 0, 0, 12}, '{1, 1, 1, 0, 0, 13}, 0, 0, 0, 0, 1, 11, 0},
	'{"issue_12", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 12, 0},
	'{"backpress", 0, 0, NO_INST, NO_INST, 1, 44, 0, 0, 0, 0, 0},
	'{"unit_ready", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 8, 0},
	'{"issue_13", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 13, 0},
	'{"pre_flush", 0, 0, '{1, 1, 1, 0, 0, 14}, '{1, 0, 1, 46, 0, 15}, 0, 0, 0, 0, 0, 0, 0},
	'{"flush", 0, 1, '{1, 1, 1, 0, 0, 16}, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"stale_cdb", 1, 0, NO_INST, NO_INST, 1, 45, 1, 46, 0, 0, 0},
	'{"flushed", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0},
	'{"refill_a", 0, 0, '{1, 1, 1, 0, 0, 17}, '{1, 1, 1, 0, 0, 18}, 0, 0, 0, 0, 0, 0, 0},
	'{"refill_b", 0, 0, '{1, 1, 1, 0, 0, 19}, '{1, 1, 1, 0, 0, 20}, 0, 0, 0, 0, 0, 0, 0},
	'{"full_again", 0, 0, '{1, 1, 1, 0, 0, 21}, NO_INST, 0, 0, 0, 0, 0, 0, 1},
	'{"issue_17", 1, 0, '{1, 1, 1, 0, 0, 21}, NO_INST, 0, 0, 0, 0, 1, 17, 0},
	'{"issue_21", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 21, 0},
	'{"issue_18", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 18, 0},
	'{"issue_19", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 19, 0},
	'{"issue_20", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 1, 20, 0},
	'{"final_idle", 1, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0}
};

`endif

/* test/rs_station_tb.sv */
module rs_station_tb;
	import rs_pkg::*;

	localparam int RS_SIZE = 4; // Small, so full is easy to reach
	localparam int RESET_CYCLES = 16;

	`include "rs_station_vectors.svh"

	localparam int TIMEOUT_CYCLES = NUM_ROWS + RESET_CYCLES + 20;

	// Model entry, the other fields follow from dest
	typedef struct packed {
		logic used;
		logic av;
		logic bv;
		word_t opa;
		word_t opb;
		prf_tag_t dest;
	} slot_t;

	logic clock, reset, rs_free, fu_ready;
	logic inst1_valid, inst1_opa_valid, inst1_opb_valid;
	word_t inst1_opa, inst1_opb;
	alu_func_e inst1_alu_func;
	fu_select_e inst1_fu_select;
	op_type_t inst1_op_type;
	prf_tag_t inst1_dest_tag;
	rob_idx_t inst1_rob_idx;
	logic inst2_valid, inst2_opa_valid, inst2_opb_valid;
	word_t inst2_opa, inst2_opb;
	alu_func_e inst2_alu_func;
	fu_select_e inst2_fu_select;
	op_type_t inst2_op_type;
	prf_tag_t inst2_dest_tag;
	rob_idx_t inst2_rob_idx;
	logic cdb1_valid, cdb2_valid;
	prf_tag_t cdb1_tag, cdb2_tag;
	word_t cdb1_value, cdb2_value;
	logic dispatch_stall, issue_valid;
	word_t issue_opa, issue_opb;
	prf_tag_t issue_dest_tag;
	alu_func_e issue_alu_func;
	fu_select_e issue_fu_select;
	op_type_t issue_op_type;
	rob_idx_t issue_rob_idx;

	integer seed; // $random state
	int cycle_count = 0;
	slot_t model [RS_SIZE]; // Reference state, one per entry
	logic model_valid; // Model's issue_valid this cycle
	logic model_stall;
	slot_t model_issue; // Granted model entry, zero when idle

	rs_station #(.RS_SIZE(RS_SIZE)) rs_station_inst (.*);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock; // Period 4
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run timed out after %0d cycles before the table finished", cycle_count);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic word_t random_word();
		return {$random(seed), $random(seed)};
	endfunction

	// Side fields derived from the destination tag
	function automatic alu_func_e func_for(prf_tag_t dest);
		return alu_func_e'(5'(dest % 6'd11) + 5'd1); // ALU_ADD up to ALU_CMPEQ
	endfunction

	function automatic fu_select_e unit_for(prf_tag_t dest);
		return fu_select_e'(3'(dest[1:0]) + 3'd1); // Never FU_DEFAULT
	endfunction

	function automatic op_type_t class_for(prf_tag_t dest);
		return op_type_t'(dest ^ 6'h15);
	endfunction

	function automatic rob_idx_t rob_for(prf_tag_t dest);
		return rob_idx_t'(dest + 6'd9);
	endfunction

	task automatic drive_inst(input inst_t in, output logic valid, output logic a_valid,
		output logic b_valid, output word_t opa, output word_t opb, output alu_func_e func,
		output fu_select_e unit, output op_type_t op_class, output prf_tag_t dest,
		output rob_idx_t rob);
		word_t a_rand;
		word_t b_rand;
		a_rand = random_word(); // Drawn every row, keeps the stream fixed
		b_rand = random_word();
		valid = in.v;
		a_valid = in.av;
		b_valid = in.bv;
		opa = in.av ? a_rand : word_t'(in.a_tag); // Waiting operand carries its tag
		opb = in.bv ? b_rand : word_t'(in.b_tag);
		func = func_for(in.dest);
		unit = unit_for(in.dest);
		op_class = class_for(in.dest);
		dest = in.dest;
		rob = rob_for(in.dest);
	endtask

	task automatic drive_row(input row_t row);
		fu_ready = row.fu_ready;
		rs_free = row.rs_free;
		drive_inst(row.i1, inst1_valid, inst1_opa_valid, inst1_opb_valid, inst1_opa,
			inst1_opb, inst1_alu_func, inst1_fu_select, inst1_op_type, inst1_dest_tag,
			inst1_rob_idx);
		drive_inst(row.i2, inst2_valid, inst2_opa_valid, inst2_opb_valid, inst2_opa,
			inst2_opb, inst2_alu_func, inst2_fu_select, inst2_op_type, inst2_dest_tag,
			inst2_rob_idx);
		cdb1_valid = row.c1_valid;
		cdb1_tag = row.c1_tag;
		cdb1_value = random_word();
		cdb2_valid = row.c2_valid;
		cdb2_tag = row.c2_tag;
		cdb2_value = random_word();
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Outputs for this cycle, then the state after the next edge
	task automatic step_model();
		logic [RS_SIZE-1:0] ready;
		int grant_slot;
		int first_free;
		int second_free;
		int inst2_slot;
		int free_count;
		int req_count;
		slot_t nxt;
		grant_slot = -1;
		first_free = -1;
		second_free = -1;
		free_count = 0;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			ready[i] = model[i].used && model[i].av && model[i].bv;
			if (fu_ready && ready[i] && grant_slot < 0)
				grant_slot = i; // Lowest ready wins
		end
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (ready[i] ? (i == grant_slot) : !model[i].used) // Issuing entry reusable
			begin
				free_count++;
				if (first_free < 0)
					first_free = i;
				else if (second_free < 0)
					second_free = i;
			end
		end
		req_count = int'(inst1_valid) + int'(inst2_valid);
		model_stall = free_count < req_count;
		model_valid = grant_slot >= 0;
		model_issue = '0;
		if (model_valid)
			model_issue = model[grant_slot];
		inst2_slot = inst1_valid ? second_free : first_free;
		for (int i = 0; i < RS_SIZE; i++)
		begin
			nxt = model[i];
			if (i == grant_slot)
				nxt.used = 1'b0;
			if (rs_free)
			begin
				nxt.used = 1'b0; // Flush beats loads
				nxt.av = 1'b0;
				nxt.bv = 1'b0;
			end
			else if (!model_stall && inst1_valid && i == first_free)
				nxt = '{1'b1, inst1_opa_valid, inst1_opb_valid, inst1_opa, inst1_opb,
					inst1_dest_tag};
			else if (!model_stall && inst2_valid && i == inst2_slot)
				nxt = '{1'b1, inst2_opa_valid, inst2_opb_valid, inst2_opa, inst2_opb,
					inst2_dest_tag};
			else if (model[i].used)
			begin
				// CDB2 applied second
				if (cdb1_valid && !model[i].av && cdb1_tag == prf_tag_t'(model[i].opa))
				begin
					nxt.opa = cdb1_value;
					nxt.av = 1'b1;
				end
				if (cdb1_valid && !model[i].bv && cdb1_tag == prf_tag_t'(model[i].opb))
				begin
					nxt.opb = cdb1_value;
					nxt.bv = 1'b1;
				end
				if (cdb2_valid && !model[i].av && cdb2_tag == prf_tag_t'(model[i].opa))
				begin
					nxt.opa = cdb2_value;
					nxt.av = 1'b1;
				end
				if (cdb2_valid && !model[i].bv && cdb2_tag == prf_tag_t'(model[i].opb))
				begin
					nxt.opb = cdb2_value;
					nxt.bv = 1'b1;
				end
			end
			model[i] = nxt;
		end
	endtask

	////////////////////
	// Compare tasks
	////////////////////

	task automatic stop_with_failure();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string test, input string field, input word_t expected,
		input word_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s %s expected %h actual %h", test, field, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_tag(input string test, input string field,
		input prf_tag_t expected, input prf_tag_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", test, field, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string test, input string field, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s %s expected %b actual %b", test, field, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_alu(input string test, input alu_func_e expected,
		input alu_func_e actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s issue_alu_func expected %0d actual %0d", test, expected,
				actual);
			stop_with_failure();
		end
	endtask

	task automatic check_unit(input string test, input fu_select_e expected,
		input fu_select_e actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s issue_fu_select expected %0d actual %0d", test, expected,
				actual);
			stop_with_failure();
		end
	endtask

	task automatic check_class(input string test, input op_type_t expected,
		input op_type_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s issue_op_type expected %h actual %h", test, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_rob(input string test, input rob_idx_t expected,
		input rob_idx_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s issue_rob_idx expected %h actual %h", test, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic compare_row(input row_t row);
		alu_func_e exp_func;
		fu_select_e exp_unit;
		op_type_t exp_class;
		rob_idx_t exp_rob;
		exp_func = row.exp_valid ? func_for(row.exp_dest) : ALU_DEFAULT; // Idle means default
		exp_unit = row.exp_valid ? unit_for(row.exp_dest) : FU_DEFAULT;
		exp_class = row.exp_valid ? class_for(row.exp_dest) : '0;
		exp_rob = row.exp_valid ? rob_for(row.exp_dest) : '0;
		check_flag(row.name, "issue_valid", row.exp_valid, issue_valid);
		check_flag(row.name, "dispatch_stall", row.exp_stall, dispatch_stall);
		check_tag(row.name, "issue_dest_tag", row.exp_dest, issue_dest_tag);
		check_flag(row.name, "model issue_valid", model_valid, issue_valid);
		check_flag(row.name, "model dispatch_stall", model_stall, dispatch_stall);
		check_tag(row.name, "model issue_dest_tag", model_issue.dest, issue_dest_tag);
		check_word(row.name, "issue_opa", model_issue.opa, issue_opa);
		check_word(row.name, "issue_opb", model_issue.opb, issue_opb);
		check_alu(row.name, exp_func, issue_alu_func);
		check_unit(row.name, exp_unit, issue_fu_select);
		check_class(row.name, exp_class, issue_op_type);
		check_rob(row.name, exp_rob, issue_rob_idx);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		seed = 32'h0828_93f1;
		reset = 1'b1;
		drive_row('{"init", 0, 0, NO_INST, NO_INST, 0, 0, 0, 0, 0, 0, 0}); // All inputs quiet
		for (int i = 0; i < RS_SIZE; i++)
			model[i] = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(negedge clock); // Drive away from the sampling edge
			drive_row(rows[r]);
			#1;
			step_model();
			compare_row(rows[r]);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+test
src/rs_pkg.sv
src/cdb_if.sv
src/rs_entry_if.sv
src/rs_entry.sv
src/rs_dispatch.sv
src/rs_issue_select.sv
src/rs_station.sv
test/rs_station_tb.sv
